//--- list.f
+incdir+.
router_pkg.sv
flit_fifo.sv
input_port.sv
switch_alloc.sv
crossbar_stage.sv
router_top.sv
tb_checker.sv
tb_router.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_router -f list.f

output=$(./obj_dir/Vtb_router)
echo "$output"

if grep -q "Test completed successfully" <<< "$output"; then
	exit 0
fi
exit 1

//--- tb_router.sv
`default_nettype none

`include "router_consts.svh"

module tb_router;

	import router_pkg::*;

	localparam int P           = `ROUTER_PORTS;
	localparam int RAND_CYCLES = 400;

	logic       clk;
	logic       arst_n;
	port_chan_t chan_in  [P-1:0];
	port_chan_t chan_out [P-1:0];
	logic       lat_probe;
	logic       done;
	logic       reported;
	int         err_count;

	logic [15:0]        lfsr;
	int                 src_cred [P]; // upstream view of each input FIFO
	int                 pkt_left [P];
	logic [`PORT_W-1:0] pkt_dest [P];
	logic [P-1:0]       hold;         // withhold downstream credits
	int                 due_q    [P][$];
	int                 out_seen [P];
	int                 cyc;
	logic               timed_out;
	int                 waited;

	router_top i_dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.chan_in  (chan_in),
		.chan_out (chan_out)
	);

	tb_checker i_checker (
		.clk       (clk),
		.arst_n    (arst_n),
		.chan_in   (chan_in),
		.chan_out  (chan_out),
		.lat_probe (lat_probe),
		.done      (done),
		.err_count (err_count),
		.reported  (reported)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic drained();
		for (int p = 0; p < P; p++) begin
			if (src_cred[p] != `BUF_DEPTH || due_q[p].size() != 0 || pkt_left[p] != 0) return 1'b0;
		end
		return 1'b1;
	endfunction

	// next cycle, then sample outputs and play the downstream side
	task automatic tick();
		@(posedge clk);
		#10;
		cyc++;
		for (int p = 0; p < P; p++) begin
			chan_in[p].flit_wr = 1'b0;
			chan_in[p].credit  = 1'b0;
			if (chan_out[p].credit) src_cred[p]++;
			if (chan_out[p].flit_wr) begin
				out_seen[p]++;
				due_q[p].push_back(cyc + int'(rand_bits(2))); // 0 to 3 cycles late
			end
			if (!hold[p] && due_q[p].size() != 0 && due_q[p][0] <= cyc) begin
				chan_in[p].credit = 1'b1;
				void'(due_q[p].pop_front());
			end
		end
	endtask

	task automatic send_flit(input int i, input flit_kind_e kind, input logic [`PORT_W-1:0] dest);
		chan_in[i].flit_wr   = 1'b1;
		chan_in[i].flit.kind = kind;
		chan_in[i].flit.dest = dest;
		chan_in[i].flit.src  = `PORT_W'(i);
		chan_in[i].flit.data = `FLIT_DATA_W'(rand_bits(`FLIT_DATA_W));
		src_cred[i]--;
	endtask

	task automatic drive_source(input int i, input logic allow_new);
		int                 len;
		flit_kind_e         kind;
		logic [`PORT_W-1:0] dest;
		if (src_cred[i] == 0) return;
		if (rand_bits(1) == 0) return;
		if (pkt_left[i] == 0) begin
			if (!allow_new) return;
			len         = int'(rand_bits(2)) + 1;
			pkt_dest[i] = `PORT_W'(rand_bits(`PORT_W));
			pkt_left[i] = len;
			kind        = (len == 1) ? flit_single : flit_head;
			dest        = pkt_dest[i];
		end else begin
			kind = (pkt_left[i] == 1) ? flit_tail : flit_body;
			dest = `PORT_W'(rand_bits(`PORT_W)); // not a route in body or tail
		end
		pkt_left[i]--;
		send_flit(i, kind, dest);
	endtask

	task automatic latency_test();
		lat_probe = 1'b1;
		tick();
		send_flit(2, flit_single, `PORT_W'(3));
		waited = 0;
		while (out_seen[3] == 0 && waited < 10) begin
			tick();
			waited++;
		end
		if (out_seen[3] == 0) begin
			$display("lone flit never left output 3 in the latency test");
			timed_out = 1'b1;
		end
		tick(); // let the checker see that cycle
		lat_probe = 1'b0;
	endtask

	task automatic stall_test();
		int sent;
		sent    = 0;
		hold    = '0;
		hold[1] = 1'b1;
		waited  = 0;
		while (out_seen[1] < `BUF_DEPTH && waited < 200) begin
			tick();
			waited++;
			if (sent < 6 && src_cred[0] > 0) begin
				send_flit(0, flit_single, `PORT_W'(1));
				sent++;
			end
		end
		if (out_seen[1] < `BUF_DEPTH) begin
			$display("output 1 never used up its downstream credits");
			timed_out = 1'b1;
		end
		repeat (20) begin // output must stay stopped here
			tick();
			if (sent < 6 && src_cred[0] > 0) begin
				send_flit(0, flit_single, `PORT_W'(1));
				sent++;
			end
		end
		hold = '0;
	endtask

	task automatic random_traffic();
		int n;
		n = 0;
		while ((n < RAND_CYCLES || !drained()) && n < RAND_CYCLES + 500) begin
			tick();
			for (int i = 0; i < P; i++) drive_source(i, n < RAND_CYCLES);
			n++;
		end
	endtask

	task automatic drain();
		waited = 0;
		while (!drained() && waited < 2000) begin
			tick();
			waited++;
		end
		if (!drained()) begin
			$display("router did not drain, flits or credits are stuck");
			timed_out = 1'b1;
		end
	endtask

	initial begin
		arst_n    = 1'b0;
		lat_probe = 1'b0;
		done      = 1'b0;
		hold      = '0;
		lfsr      = 16'd72;
		cyc       = 0;
		timed_out = 1'b0;
		for (int p = 0; p < P; p++) begin
			chan_in[p]  = '0;
			src_cred[p] = `BUF_DEPTH;
			pkt_left[p] = 0;
			pkt_dest[p] = '0;
			out_seen[p] = 0;
		end
		repeat (10) @(posedge clk);
		#10;
		arst_n = 1'b1;
		repeat (10) tick(); // outputs stay quiet while idle
		latency_test();
		if (!timed_out) drain();
		if (!timed_out) stall_test();
		if (!timed_out) drain();
		if (!timed_out) random_traffic();
		if (!timed_out) drain();
		done   = 1'b1;
		waited = 0;
		while (!reported && waited < 10) begin
			tick();
			waited++;
		end
		if (!reported) $display("checker gave no summary");
		if (timed_out || !reported || err_count != 0) begin
			$display("Test failed");
		end else begin
			$display("Test completed successfully");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_checker.sv
`default_nettype none

`include "router_consts.svh"

module tb_checker (
	input  logic                   clk,
	input  logic                   arst_n,
	input  router_pkg::port_chan_t chan_in  [`ROUTER_PORTS-1:0],
	input  router_pkg::port_chan_t chan_out [`ROUTER_PORTS-1:0],
	input  logic                   lat_probe, // lone flit latency test running
	input  logic                   done,
	output int                     err_count,
	output logic                   reported
);

	import router_pkg::*;

	localparam int P = `ROUTER_PORTS;

	flit_t              exp_q [P*P][$]; // [src*P + dest]
	logic [`PORT_W-1:0] pkt_dest  [P];  // dest of the packet entering each input
	int                 wr_cnt    [P];
	int                 cr_cnt    [P];
	int                 emit_cnt  [P];
	int                 ret_cnt   [P];
	logic               out_busy  [P];
	logic [`PORT_W-1:0] out_owner [P];
	int                 edge_cnt;
	int                 flits_checked;
	int                 lat_edge;
	int                 lat_in;
	int                 lat_out;
	logic               any_written;

	task automatic show_mismatch(input string name, input logic [31:0] want,
			input logic [31:0] got);
		$display("ERROR %s: expected %0h, actual %0h", name, want, got);
		err_count++;
	endtask

	task automatic show_problem(input string msg);
		$display("%s", msg);
		err_count++;
	endtask

	task automatic check_output(input int o, input flit_t f);
		int    key;
		flit_t want;
		key = int'(f.src) * P + o;
		if (exp_q[key].size() == 0) begin
			show_problem($sformatf("output %0d sent a flit from input %0d that was never written",
				o, f.src));
		end else begin
			want = exp_q[key].pop_front();
			if (want != f) show_mismatch("flit_integrity", 32'(want), 32'(f));
			flits_checked++;
		end
		// one packet owns the output from head to tail
		case (f.kind)
			flit_head: begin
				if (out_busy[o]) begin
					show_problem($sformatf("head flit on output %0d inside a packet", o));
				end
				out_busy[o]  = 1'b1;
				out_owner[o] = f.src;
			end
			flit_single: begin
				if (out_busy[o]) begin
					show_problem($sformatf("single flit on output %0d inside a packet", o));
				end
			end
			default: begin
				if (!out_busy[o]) begin
					show_problem($sformatf("body or tail flit on output %0d with no open packet", o));
				end else if (out_owner[o] != f.src) begin
					show_mismatch("no_interleave", 32'(out_owner[o]), 32'(f.src));
				end
				if (f.kind == flit_tail) out_busy[o] = 1'b0;
			end
		endcase
	endtask

	task automatic final_report();
		int credits_total;
		credits_total = 0;
		for (int k = 0; k < P*P; k++) begin
			if (exp_q[k].size() != 0) begin
				show_problem($sformatf("%0d flits from input %0d to output %0d never came out",
					exp_q[k].size(), k / P, k % P));
			end
		end
		for (int p = 0; p < P; p++) begin
			if (cr_cnt[p] != wr_cnt[p]) show_mismatch("credit_total", wr_cnt[p], cr_cnt[p]);
			if (out_busy[p]) show_problem($sformatf("output %0d is still inside a packet", p));
			credits_total += cr_cnt[p];
		end
		$display("checker summary: %0d flits checked, %0d credit pulses, %0d errors",
			flits_checked, credits_total, err_count);
		reported = 1'b1;
	endtask

	// sampled mid-cycle, where inputs and outputs are both settled
	always @(negedge clk) begin
		if (!arst_n) begin
			err_count     = 0;
			flits_checked = 0;
			edge_cnt      = 0;
			lat_edge      = -100;
			lat_in        = 0;
			lat_out       = 0;
			any_written   = 1'b0;
			reported      = 1'b0;
			for (int p = 0; p < P; p++) begin
				wr_cnt[p]    = 0;
				cr_cnt[p]    = 0;
				emit_cnt[p]  = 0;
				ret_cnt[p]   = 0;
				out_busy[p]  = 1'b0;
				out_owner[p] = '0;
				pkt_dest[p]  = '0;
			end
		end else begin
			edge_cnt++;
			for (int p = 0; p < P; p++) begin
				if (!any_written && (chan_out[p].flit_wr || chan_out[p].credit)) begin
					show_mismatch("reset_state", 0,
						32'({chan_out[p].flit_wr, chan_out[p].credit}));
				end
			end
			for (int i = 0; i < P; i++) begin
				if (chan_in[i].flit_wr) begin
					any_written = 1'b1;
					wr_cnt[i]++;
					if (chan_in[i].flit.kind == flit_head ||
							chan_in[i].flit.kind == flit_single) begin
						pkt_dest[i] = chan_in[i].flit.dest;
					end
					exp_q[i*P + int'(pkt_dest[i])].push_back(chan_in[i].flit);
					if (lat_probe) begin
						lat_edge = edge_cnt;
						lat_in   = i;
						lat_out  = int'(pkt_dest[i]);
					end
				end
				if (chan_in[i].credit) ret_cnt[i]++;
			end
			for (int o = 0; o < P; o++) begin
				if (chan_out[o].flit_wr) begin
					check_output(o, chan_out[o].flit);
					emit_cnt[o]++;
					if (lat_probe) begin
						if (o != lat_out) show_mismatch("latency_port", lat_out, o);
						if (edge_cnt - lat_edge != 2) begin
							show_mismatch("latency", 2, edge_cnt - lat_edge);
						end
						// freed input slot reported on the same edge
						if (!chan_out[lat_in].credit) show_mismatch("latency_credit", 1, 0);
					end
				end
				if (chan_out[o].credit) begin
					cr_cnt[o]++;
					if (cr_cnt[o] > wr_cnt[o]) begin
						show_mismatch("credit_return", wr_cnt[o], cr_cnt[o]);
					end
					if (lat_probe && o == lat_in && edge_cnt - lat_edge != 2) begin
						show_mismatch("latency_credit", 2, edge_cnt - lat_edge);
					end
				end
				if (emit_cnt[o] - ret_cnt[o] > `BUF_DEPTH) begin
					show_mismatch("downstream_credit", `BUF_DEPTH, emit_cnt[o] - ret_cnt[o]);
				end
			end
			if (done && !reported) final_report();
		end
	end

endmodule

`default_nettype wire

//--- router_top.sv
`default_nettype none

`include "router_consts.svh"

module router_top (
	input  logic                   clk,
	input  logic                   arst_n,
	input  router_pkg::port_chan_t chan_in  [`ROUTER_PORTS-1:0],
	output router_pkg::port_chan_t chan_out [`ROUTER_PORTS-1:0]
);

	import router_pkg::*;

	flit_t                    head_flit [`ROUTER_PORTS-1:0];
	logic [`ROUTER_PORTS-1:0] req;
	logic [`PORT_W-1:0]       req_port  [`ROUTER_PORTS-1:0];
	logic [`ROUTER_PORTS-1:0] req_last;
	logic [`ROUTER_PORTS-1:0] grant;
	logic [`ROUTER_PORTS-1:0] credit_in; // from downstream, per output
	logic [`PORT_W-1:0]       out_sel   [`ROUTER_PORTS-1:0];
	logic [`ROUTER_PORTS-1:0] out_valid;

	for (genvar i = 0; i < `ROUTER_PORTS; i++) begin : g_port
		assign credit_in[i] = chan_in[i].credit;

		input_port i_input_port (
			.clk       (clk),
			.arst_n    (arst_n),
			.chan      (chan_in[i]),
			.grant     (grant[i]),
			.head_flit (head_flit[i]),
			.req       (req[i]),
			.req_port  (req_port[i]),
			.req_last  (req_last[i])
		);
	end

	switch_alloc i_switch_alloc (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.req_port  (req_port),
		.req_last  (req_last),
		.credit_in (credit_in),
		.grant     (grant),
		.out_sel   (out_sel),
		.out_valid (out_valid)
	);

	crossbar_stage i_crossbar_stage (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_flit   (head_flit),
		.grant     (grant),
		.out_sel   (out_sel),
		.out_valid (out_valid),
		.chan_out  (chan_out)
	);

endmodule

`default_nettype wire

//--- crossbar_stage.sv
`default_nettype none

`include "router_consts.svh"

module crossbar_stage (
	input  logic                     clk,
	input  logic                     arst_n,
	input  router_pkg::flit_t        in_flit [`ROUTER_PORTS-1:0],
	input  logic [`ROUTER_PORTS-1:0] grant,
	input  logic [`PORT_W-1:0]       out_sel [`ROUTER_PORTS-1:0],
	input  logic [`ROUTER_PORTS-1:0] out_valid,
	output router_pkg::port_chan_t   chan_out [`ROUTER_PORTS-1:0]
);

	import router_pkg::*;

	logic [`ROUTER_PORTS-1:0] flit_wr_q;
	logic [`ROUTER_PORTS-1:0] credit_q; // indexed by input
	flit_t                    flit_q [`ROUTER_PORTS-1:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flit_wr_q <= '0;
			credit_q  <= '0;
		end else begin
			flit_wr_q <= out_valid;
			credit_q  <= grant; // slot freed in that input's FIFO
		end
	end

	// switch traversal
	always_ff @(posedge clk) begin
		for (int o = 0; o < `ROUTER_PORTS; o++) begin
			if (out_valid[o]) begin
				flit_q[o] <= in_flit[out_sel[o]];
			end
		end
	end

	always_comb begin
		for (int p = 0; p < `ROUTER_PORTS; p++) begin
			chan_out[p].flit_wr = flit_wr_q[p];
			chan_out[p].flit    = flit_q[p];
			chan_out[p].credit  = credit_q[p];
		end
	end

endmodule

`default_nettype wire

//--- switch_alloc.sv
`default_nettype none

`include "router_consts.svh"

module switch_alloc (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [`ROUTER_PORTS-1:0] req,
	input  logic [`PORT_W-1:0]       req_port [`ROUTER_PORTS-1:0],
	input  logic [`ROUTER_PORTS-1:0] req_last,
	input  logic [`ROUTER_PORTS-1:0] credit_in,
	output logic [`ROUTER_PORTS-1:0] grant,
	output logic [`PORT_W-1:0]       out_sel [`ROUTER_PORTS-1:0],
	output logic [`ROUTER_PORTS-1:0] out_valid
);

	// per output state
	logic [`ROUTER_PORTS-1:0] locked;
	logic [`PORT_W-1:0]       owner   [`ROUTER_PORTS-1:0];
	logic [`PORT_W-1:0]       rr_ptr  [`ROUTER_PORTS-1:0]; // last input served
	logic [`CREDIT_W-1:0]     credits [`ROUTER_PORTS-1:0];

	// [output][input]
	logic [`ROUTER_PORTS-1:0][`ROUTER_PORTS-1:0] req_for;

	always_comb begin
		for (int o = 0; o < `ROUTER_PORTS; o++) begin
			for (int i = 0; i < `ROUTER_PORTS; i++) begin
				req_for[o][i] = req[i] && (req_port[i] == `PORT_W'(o));
			end
		end
	end

	always_comb begin
		logic [`PORT_W-1:0] idx;
		logic               found;
		for (int o = 0; o < `ROUTER_PORTS; o++) begin
			out_valid[o] = 1'b0;
			out_sel[o]   = '0;
			found        = 1'b0;
			idx          = '0;
			if (credits[o] != '0) begin // no credit, no grant
				if (locked[o]) begin
					if (req_for[o][owner[o]]) begin
						out_valid[o] = 1'b1;
						out_sel[o]   = owner[o];
					end
				end else begin
					// round robin, starting just after the pointer
					for (int k = 1; k <= `ROUTER_PORTS; k++) begin
						idx = `PORT_W'((int'(rr_ptr[o]) + k) % `ROUTER_PORTS);
						if (!found && req_for[o][idx]) begin
							found        = 1'b1;
							out_valid[o] = 1'b1;
							out_sel[o]   = idx;
						end
					end
				end
			end
		end
	end

	// each input asks for one output, so at most one bit lands per input
	always_comb begin
		grant = '0;
		for (int o = 0; o < `ROUTER_PORTS; o++) begin
			for (int i = 0; i < `ROUTER_PORTS; i++) begin
				if (out_valid[o] && out_sel[o] == `PORT_W'(i)) begin
					grant[i] = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			locked <= '0;
			for (int o = 0; o < `ROUTER_PORTS; o++) begin
				owner[o]   <= '0;
				rr_ptr[o]  <= '1; // input 0 goes first
				credits[o] <= `CREDIT_W'(`BUF_DEPTH);
			end
		end else begin
			for (int o = 0; o < `ROUTER_PORTS; o++) begin
				if (out_valid[o]) begin
					// head locks, tail releases, single does both at once
					locked[o] <= ~req_last[out_sel[o]];
					owner[o]  <= out_sel[o];
					rr_ptr[o] <= out_sel[o];
				end
				if (out_valid[o] && !credit_in[o]) begin
					credits[o] <= credits[o] - 1'b1;
				end else if (!out_valid[o] && credit_in[o]) begin
					credits[o] <= credits[o] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- input_port.sv
`default_nettype none

`include "router_consts.svh"

module input_port (
	input  logic                   clk,
	input  logic                   arst_n,
	input  router_pkg::port_chan_t chan,
	input  logic                   grant,
	output router_pkg::flit_t      head_flit,
	output logic                   req,
	output logic [`PORT_W-1:0]     req_port,
	output logic                   req_last
);

	import router_pkg::*;

	logic [`FLIT_DATA_W+5:0] fifo_dout;
	logic                    fifo_empty;
	pkt_state_e              state;
	logic [`PORT_W-1:0]      dest_q; // output of the packet in flight

	flit_fifo i_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.push   (chan.flit_wr),
		.pop    (grant),       // grant pops in the same cycle
		.din    (chan.flit),
		.dout   (fifo_dout),
		.empty  (fifo_empty)
	);

	assign head_flit = flit_t'(fifo_dout);

	// packet tracking, only granted flits move the state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= pkt_idle;
		end else if (grant) begin
			case (head_flit.kind)
				flit_head: state <= pkt_in_packet;
				flit_tail: state <= pkt_idle;
				default:   state <= state; // body keeps, single never enters
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (grant && head_flit.kind == flit_head) begin
			dest_q <= head_flit.dest;
		end
	end

	assign req = ~fifo_empty;

	// body and tail follow the head's output
	assign req_port = (state == pkt_in_packet) ? dest_q : head_flit.dest;

	assign req_last = (head_flit.kind == flit_tail) || (head_flit.kind == flit_single);

endmodule

`default_nettype wire

//--- flit_fifo.sv
`default_nettype none

`include "router_consts.svh"

module flit_fifo (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      push,
	input  logic                      pop,
	input  logic [`FLIT_DATA_W+5:0]   din,
	output logic [`FLIT_DATA_W+5:0]   dout,
	output logic                      empty
);

	localparam int PTR_W = (`BUF_DEPTH > 1) ? $clog2(`BUF_DEPTH) : 1;

	logic [`FLIT_DATA_W+5:0] mem [`BUF_DEPTH-1:0];
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [`CREDIT_W-1:0]    count; // 0 .. BUF_DEPTH

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`BUF_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= ptr_next(wr_ptr);
			if (pop) rd_ptr <= ptr_next(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // none or both
			endcase
		end
	end

	// storage, upstream credits keep it from overflowing
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	assign dout  = mem[rd_ptr];
	assign empty = (count == '0);

endmodule

`default_nettype wire

//--- router_pkg.sv
`default_nettype none

`include "router_consts.svh"

package router_pkg;

	typedef enum logic [1:0] {
		flit_head   = 2'b00,
		flit_body   = 2'b01,
		flit_tail   = 2'b10,
		flit_single = 2'b11 // head and tail in one
	} flit_kind_e;

	// wormhole state of one input
	typedef enum logic {
		pkt_idle      = 1'b0,
		pkt_in_packet = 1'b1
	} pkt_state_e;

	typedef struct packed {
		flit_kind_e              kind;
		logic [`PORT_W-1:0]      dest; // valid in head and single
		logic [`PORT_W-1:0]      src;  // set by the sender
		logic [`FLIT_DATA_W-1:0] data;
	} flit_t;

	typedef struct packed {
		logic  flit_wr;
		flit_t flit;
		logic  credit; // one buffer slot returned
	} port_chan_t;

endpackage

`default_nettype wire

//--- router_consts.svh
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// router geometry
`define ROUTER_PORTS 4
`define PORT_W       2 // bits of a port index

// flit payload
`define FLIT_DATA_W  16

// input buffer slots per port, also the start credit of every output
`define BUF_DEPTH    4

// holds 0 up to BUF_DEPTH
`define CREDIT_W     3

`endif
